//--- compile.f
hw/game_pkg.sv
hw/pixel_pkg.sv
hw/motion_if.sv
hw/game_control.sv
hw/playfield_state.sv
hw/sprite_plotter.sv
hw/score_bcd_counter.sv
hw/bouncy_ball_top.sv
testbench/tb_plotter_props.sv
testbench/tb_bouncy_ball.sv

//--- Bender.yml
package:
  name: bouncy_ball

sources:
  - hw/game_pkg.sv
  - hw/pixel_pkg.sv
  - hw/motion_if.sv
  - hw/game_control.sv
  - hw/playfield_state.sv
  - hw/sprite_plotter.sv
  - hw/score_bcd_counter.sv
  - hw/bouncy_ball_top.sv
  - target: test
    files:
      - testbench/tb_plotter_props.sv
      - testbench/tb_bouncy_ball.sv

//--- testbench/tb_bouncy_ball.sv
module tb_bouncy_ball;
    import game_pkg::*;
    import pixel_pkg::*;

    localparam int unsigned FRAME_CYCLES = 16;
    localparam int unsigned PLOT_CREDITS = 4;
    localparam int NUM_GAMES   = 3;
    localparam int MAX_FRAMES  = 1500;
    localparam int CYCLE_LIMIT = MAX_FRAMES * (48 * 8 + FRAME_CYCLES + 8);

    logic        clk, resetn, go, left_key, right_key, plot_credit;
    logic        plot_valid, playing;
    x_coord_t    plot_x;
    y_coord_t    plot_y;
    colour_t     plot_colour;
    logic [11:0] score_bcd;

    // Reference model of the playfield
    int        m_bx, m_by, m_px, m_score;
    ball_dir_e m_dir;
    logic      in_game, game_ended, next_left, next_right;
    int        pix_idx, outstanding, hold, frames, frames_in_game, game_idx, idle_gap;
    int        hits, bounces, left_stops, right_stops, cycles, checks;
    int        err [6];
    logic [31:0] rng;

    const int bdx [12] = '{1, 2, 0, 1, 2, 3, 0, 1, 2, 3, 1, 2};
    const int bdy [12] = '{0, 0, 1, 1, 1, 1, 2, 2, 2, 2, 3, 3};

    bouncy_ball_top #(
        .FRAME_CYCLES(FRAME_CYCLES),
        .PLOT_CREDITS(PLOT_CREDITS)
    ) uut (.*);

    bind sprite_plotter tb_plotter_props #(
        .PLOT_CREDITS(PLOT_CREDITS),
        .CRED_W      (CRED_W)
    ) u_props (
        .clk        (clk),
        .resetn     (resetn),
        .draw_start (draw_start),
        .draw_done  (draw_done),
        .plot_valid (plot_valid),
        .plot_credit(plot_credit),
        .credits    (credits)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    function automatic logic [11:0] to_bcd(input int v);
        return {4'(v / 100), 4'((v / 10) % 10), 4'(v % 10)};
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Ends the frame in the model: paddle, collision, bounce, ball move
    task automatic advance_model();
        logic down, left, pad, wall;
        if (next_left) begin  // Left wins when both held
            if (m_px > 1)
                m_px--;
            else
                left_stops++;
        end else if (next_right) begin
            if (m_px < 140)
                m_px++;
            else
                right_stops++;
        end
        down = (m_dir == down_right) || (m_dir == down_left);
        left = (m_dir == down_left) || (m_dir == up_left);
        pad  = (m_by == 113) && down && (m_bx + 3 >= m_px) && (m_bx <= m_px + 17);
        wall = pad || (m_bx <= 1) || (m_bx >= 155) || (m_by <= 1);
        if (m_by >= 115) begin
            in_game    = 1'b0;
            game_ended = 1'b1;
            return;
        end
        if (pad) begin
            m_score = (m_score + 1) % 1000;
            hits++;
        end
        if (wall) begin
            if (m_bx <= 1)
                left = 1'b0;
            else if (m_bx >= 155)
                left = 1'b1;
            if (m_by <= 1)
                down = 1'b1;
            else if (pad)
                down = 1'b0;
            m_dir = down ? (left ? down_left : down_right) : (left ? up_left : up_right);
            bounces++;
        end
        m_bx = left ? m_bx - 1 : m_bx + 1;
        m_by = down ? m_by + 1 : m_by - 1;
    endtask

    // Steer toward the ball early in a game, then pin the paddle to a wall
    task automatic choose_keys();
        rng = xorshift(rng);
        if (frames_in_game < 120 && rng[2:0] != 3'd0) begin
            next_left  = m_px > m_bx - 7;
            next_right = m_px < m_bx - 7;
        end else if (frames_in_game >= 120 && frames_in_game < 400) begin
            next_left  = (game_idx % 2 == 0);
            next_right = 1'b1;
        end else begin
            next_left  = rng[3];
            next_right = rng[4];
        end
    endtask

    // Pixel monitor and credit accounting
    always @(posedge clk) begin
        int ex, ey, ec, e;
        if (resetn) begin
            outstanding = outstanding + int'(plot_valid) - int'(plot_credit);
            assert (outstanding <= PLOT_CREDITS) else begin
                $display("Outstanding pixels %0d exceed the credit limit", outstanding);
                err[2]++;
            end
            if (plot_valid) begin
                assert (in_game) else begin
                    $display("Pixel written while no game is running");
                    err[1]++;
                end
            end
            if (plot_valid && in_game) begin
                e = (pix_idx < 12) ? 1 : 3;
                if (pix_idx < 12) begin
                    ex = m_bx + bdx[pix_idx];
                    ey = m_by + bdy[pix_idx];
                    ec = 7;
                end else begin
                    ex = m_px + (pix_idx - 12) % 18;
                    ey = (pix_idx < 30) ? 118 : 117;
                    ec = 3;
                end
                if (pix_idx == 0) begin
                    assert (score_bcd == to_bcd(m_score)) else begin
                        $display("[ERROR] score_bcd 0x%03h expected 0x%03h",
                                 score_bcd, to_bcd(m_score));
                        err[4]++;
                    end
                    assert (playing) else begin
                        $display("[ERROR] playing 0x%0h expected 0x1", playing);
                        err[5]++;
                    end
                end
                assert (plot_x == x_coord_t'(ex)) else begin
                    $display("[ERROR] plot_x 0x%02h expected 0x%02h pixel %0d",
                             plot_x, ex, pix_idx);
                    err[e]++;
                end
                assert (plot_y == y_coord_t'(ey)) else begin
                    $display("[ERROR] plot_y 0x%02h expected 0x%02h pixel %0d",
                             plot_y, ey, pix_idx);
                    err[e]++;
                end
                assert (plot_colour == colour_t'(ec)) else begin
                    $display("[ERROR] plot_colour 0x%0h expected 0x%0h", plot_colour, ec);
                    err[e]++;
                end
                checks++;
                pix_idx++;
                if (pix_idx == 48) begin
                    pix_idx = 0;
                    frames++;
                    frames_in_game++;
                    choose_keys();
                    advance_model();
                    if (game_ended)
                        idle_gap = 2 + int'(rng[9:5]);
                end
            end
        end
    end

    // Credit sink with random delays and stretches of no returns
    always @(negedge clk) begin
        logic [31:0] r;
        left_key  = next_left;
        right_key = next_right;
        r   = xorshift(rng);
        rng = r;
        if (hold > 0) begin
            hold--;
            plot_credit = 1'b0;
        end else begin
            if (r[3:0] == 4'd0)
                hold = int'(r[8:4]);
            plot_credit = resetn && (outstanding > 0) && r[9];
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the game did not end in time", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        int total;
        int drop_wait;
        rng = 32'h734;
        {go, left_key, right_key, plot_credit, next_left, next_right} = '0;
        {in_game, game_ended} = '0;
        {pix_idx, outstanding, hold, frames, frames_in_game, cycles, checks} = '0;
        {hits, bounces, left_stops, right_stops, game_idx} = '0;
        idle_gap = 5;
        foreach (err[i]) err[i] = 0;
        resetn = 1'b0;
        repeat (4) @(negedge clk);
        resetn = 1'b1;

        repeat (20) begin
            @(negedge clk);
            assert (!plot_valid && !playing && score_bcd == 12'h000) else begin
                $display("[ERROR] idle outputs plot_valid 0x%0h playing 0x%0h score_bcd 0x%03h",
                         plot_valid, playing, score_bcd);
                err[0]++;
            end
        end
        $display("Reset and idle state: %0d errors", err[0]);

        for (game_idx = 0; game_idx < NUM_GAMES; game_idx++) begin
            repeat (idle_gap) @(negedge clk);
            m_bx = 78;
            m_by = 58;
            m_px = 71;
            m_dir = down_right;
            m_score = 0;
            frames_in_game = 0;
            pix_idx = 0;
            game_ended = 1'b0;
            in_game = 1'b1;
            go = 1'b1;
            @(negedge clk);
            go = 1'b0;
            while (!game_ended) @(negedge clk);
            // Frame wait plus the few sequencing states before game_over
            drop_wait = 0;
            while (playing && drop_wait < FRAME_CYCLES + 8) begin
                @(negedge clk);
                drop_wait++;
            end
            assert (!playing) else begin
                $display("playing stayed high after the missed ball");
                err[5]++;
            end
            repeat (3) @(negedge clk);
            assert (score_bcd == to_bcd(m_score) && !playing) else begin
                $display("[ERROR] after miss score_bcd 0x%03h expected 0x%03h playing 0x%0h",
                         score_bcd, to_bcd(m_score), playing);
                err[5]++;
            end
            $display("Game %0d over after %0d frames, score %0d", game_idx, frames_in_game,
                     m_score);
        end

        err[2] += uut.u_plotter.u_props.fail_count;
        $display("Frame pixels: %0d frames, %0d ball pixel errors", frames, err[1]);
        $display("Credit flow: %0d errors", err[2]);
        $display("Paddle keys: %0d left stops, %0d right stops, %0d errors",
                 left_stops, right_stops, err[3]);
        $display("Bounces and score: %0d bounces, %0d paddle hits, %0d errors",
                 bounces, hits, err[4]);
        $display("Miss and restart: %0d games, %0d errors", NUM_GAMES, err[5]);
        total = err[0] + err[1] + err[2] + err[3] + err[4] + err[5];
        $display("Checked %0d pixels, %0d errors", checks, total);
        if (total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/tb_plotter_props.sv
module tb_plotter_props #(
    parameter int unsigned PLOT_CREDITS = 4,
    parameter int          CRED_W       = 3
) (
    input logic              clk,
    input logic              resetn,
    input logic              draw_start,
    input logic              draw_done,
    input logic              plot_valid,
    input logic              plot_credit,
    input logic [CRED_W-1:0] credits
);

    logic              in_draw;      // Between draw_start and draw_done
    logic [CRED_W-1:0] outstanding;  // Pixels not yet paid back with a credit
    int                fail_count = 0;

    always_ff @(posedge clk) begin
        if (!resetn)
            in_draw <= 1'b0;
        else if (draw_start)
            in_draw <= 1'b1;
        else if (draw_done)
            in_draw <= 1'b0;
    end

    // Seen from the pixel port only
    always_ff @(posedge clk) begin
        if (!resetn)
            outstanding <= '0;
        else
            outstanding <= outstanding + CRED_W'(plot_valid) - CRED_W'(plot_credit);
    end

    credit_limit: assert property (@(posedge clk) disable iff (!resetn)
        credits <= PLOT_CREDITS)
        else begin
            fail_count++;
            $error("Plotter credit count %0d above its limit", credits);
        end

    valid_needs_credit: assert property (@(posedge clk) disable iff (!resetn)
        plot_valid |-> outstanding < PLOT_CREDITS)
        else begin
            fail_count++;
            $error("Pixel written with no credit left");
        end

    valid_inside_draw: assert property (@(posedge clk) disable iff (!resetn)
        plot_valid |-> in_draw)
        else begin
            fail_count++;
            $error("Pixel written outside a draw");
        end

endmodule

//--- hw/bouncy_ball_top.sv
module bouncy_ball_top #(
    parameter int unsigned FRAME_CYCLES = 16,
    parameter int unsigned PLOT_CREDITS = 4
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic                go,
    input  logic                left_key,
    input  logic                right_key,
    input  logic                plot_credit,
    output logic                plot_valid,
    output pixel_pkg::x_coord_t plot_x,
    output pixel_pkg::y_coord_t plot_y,
    output pixel_pkg::colour_t  plot_colour,
    output logic                playing,
    output logic [11:0]         score_bcd
);
    import pixel_pkg::*;

    x_coord_t ball_x, paddle_x;
    y_coord_t ball_y;
    logic     draw_start, draw_done;
    logic     score_inc, score_clear;

    motion_if motion ();

    game_control #(
        .FRAME_CYCLES(FRAME_CYCLES)
    ) u_control (
        .clk        (clk),
        .resetn     (resetn),
        .go         (go),
        .draw_done  (draw_done),
        .motion     (motion.control),
        .draw_start (draw_start),
        .score_inc  (score_inc),
        .score_clear(score_clear),
        .playing    (playing)
    );

    playfield_state u_playfield (
        .clk      (clk),
        .resetn   (resetn),
        .left_key (left_key),
        .right_key(right_key),
        .motion   (motion.playfield),
        .ball_x   (ball_x),
        .ball_y   (ball_y),
        .paddle_x (paddle_x)
    );

    sprite_plotter #(
        .PLOT_CREDITS(PLOT_CREDITS)
    ) u_plotter (
        .clk        (clk),
        .resetn     (resetn),
        .draw_start (draw_start),
        .plot_credit(plot_credit),
        .ball_x     (ball_x),
        .ball_y     (ball_y),
        .paddle_x   (paddle_x),
        .draw_done  (draw_done),
        .plot_valid (plot_valid),
        .plot_x     (plot_x),
        .plot_y     (plot_y),
        .plot_colour(plot_colour)
    );

    score_bcd_counter u_score (
        .clk        (clk),
        .resetn     (resetn),
        .score_inc  (score_inc),
        .score_clear(score_clear),
        .score_bcd  (score_bcd)
    );

endmodule

//--- hw/score_bcd_counter.sv
module score_bcd_counter (
    input  logic        clk,
    input  logic        resetn,
    input  logic        score_inc,
    input  logic        score_clear,
    output logic [11:0] score_bcd
);

    logic [11:0] next_bcd;
    logic        carry;

    // Ripple the increment through the digits, 999 wraps to 000
    always_comb begin
        next_bcd = score_bcd;
        carry    = 1'b1;
        for (int d = 0; d < 3; d++) begin
            if (carry) begin
                if (score_bcd[4*d +: 4] == 4'd9) begin
                    next_bcd[4*d +: 4] = 4'd0;
                end else begin
                    next_bcd[4*d +: 4] = score_bcd[4*d +: 4] + 4'd1;
                    carry              = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn || score_clear)
            score_bcd <= '0;
        else if (score_inc)
            score_bcd <= next_bcd;
    end

endmodule

//--- hw/sprite_plotter.sv
module sprite_plotter #(
    parameter int unsigned PLOT_CREDITS = 4
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic                draw_start,
    input  logic                plot_credit,
    input  pixel_pkg::x_coord_t ball_x,
    input  pixel_pkg::y_coord_t ball_y,
    input  pixel_pkg::x_coord_t paddle_x,
    output logic                draw_done,
    output logic                plot_valid,
    output pixel_pkg::x_coord_t plot_x,
    output pixel_pkg::y_coord_t plot_y,
    output pixel_pkg::colour_t  plot_colour
);
    import game_pkg::*;
    import pixel_pkg::*;

    localparam int BALL_PIXELS  = 12;
    localparam int TOTAL_PIXELS = BALL_PIXELS + 2 * PADDLE_WIDTH;   // 48
    localparam int CRED_W       = $clog2(PLOT_CREDITS + 1);

    // Ball sprite offsets {dx, dy}, 4x4 square without corners
    localparam logic [3:0] BALL_OFS [BALL_PIXELS] = '{
        4'b01_00, 4'b10_00,
        4'b00_01, 4'b01_01, 4'b10_01, 4'b11_01,
        4'b00_10, 4'b01_10, 4'b10_10, 4'b11_10,
        4'b01_11, 4'b10_11
    };

    logic [CRED_W-1:0] credits;
    logic [5:0]        idx;
    logic [5:0]        col;
    logic [3:0]        ofs;
    logic              busy;
    logic              last;

    assign plot_valid = busy && (credits != '0);  // Stall with no credit left
    assign last       = (idx == 6'(TOTAL_PIXELS - 1));

    always_comb begin
        ofs = 4'd0;
        col = 6'd0;
        if (idx < 6'(BALL_PIXELS)) begin
            ofs         = BALL_OFS[idx[3:0]];
            plot_x      = ball_x + x_coord_t'(ofs[3:2]);
            plot_y      = ball_y + y_coord_t'(ofs[1:0]);
            plot_colour = BALL_COLOUR;
        end else if (idx < 6'(BALL_PIXELS + PADDLE_WIDTH)) begin
            col         = idx - 6'(BALL_PIXELS);
            plot_x      = paddle_x + x_coord_t'(col);
            plot_y      = y_coord_t'(SCREEN_HEIGHT - 2);   // Bottom paddle row first
            plot_colour = PADDLE_COLOUR;
        end else begin
            col         = idx - 6'(BALL_PIXELS + PADDLE_WIDTH);
            plot_x      = paddle_x + x_coord_t'(col);
            plot_y      = y_coord_t'(SCREEN_HEIGHT - 3);
            plot_colour = PADDLE_COLOUR;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy      <= 1'b0;
            idx       <= '0;
            draw_done <= 1'b0;
        end else begin
            draw_done <= 1'b0;
            if (draw_start) begin
                busy <= 1'b1;
                idx  <= '0;
            end else if (plot_valid) begin
                idx <= idx + 1'b1;
                if (last) begin
                    busy      <= 1'b0;
                    draw_done <= 1'b1;
                end
            end
        end
    end

    // One credit spent per pixel, one returned per plot_credit cycle
    always_ff @(posedge clk) begin
        if (!resetn)
            credits <= CRED_W'(PLOT_CREDITS);
        else
            credits <= credits - CRED_W'(plot_valid) + CRED_W'(plot_credit);
    end

endmodule

//--- hw/playfield_state.sv
module playfield_state (
    input  logic                clk,
    input  logic                resetn,
    input  logic                left_key,
    input  logic                right_key,
    motion_if.playfield         motion,
    output pixel_pkg::x_coord_t ball_x,
    output pixel_pkg::y_coord_t ball_y,
    output pixel_pkg::x_coord_t paddle_x
);
    import game_pkg::*;
    import pixel_pkg::*;

    ball_dir_e  dir, bounced_dir;
    logic       moving_down;
    logic       moving_left;
    logic       paddle_hit;
    logic       wall_hit;
    logic       go_left, go_down;
    logic [8:0] ball_x_ext, paddle_x_ext;

    assign moving_down = (dir == down_right) || (dir == down_left);
    assign moving_left = (dir == down_left) || (dir == up_left);

    // 9 bits so the paddle window does not wrap near x = 0
    assign ball_x_ext   = {1'b0, ball_x};
    assign paddle_x_ext = {1'b0, paddle_x};

    assign paddle_hit = (ball_y == y_coord_t'(PADDLE_LINE_Y)) && moving_down
                        && (ball_x_ext + 9'd3 >= paddle_x_ext)
                        && (ball_x_ext <= paddle_x_ext + 9'(PADDLE_WIDTH - 1));

    assign wall_hit = paddle_hit || (ball_x <= 8'd1) || (ball_x >= WALL_RIGHT_X)
                      || (ball_y <= 7'd1);

    // Split direction into its two components and reflect each on its own
    always_comb begin
        go_left = moving_left;
        go_down = moving_down;
        if (ball_x <= 8'd1)
            go_left = 1'b0;
        else if (ball_x >= WALL_RIGHT_X)
            go_left = 1'b1;
        if (ball_y <= 7'd1)
            go_down = 1'b1;
        else if (motion.touching_paddle)
            go_down = 1'b0;
        case ({go_down, go_left})
            2'b00:   bounced_dir = up_right;
            2'b01:   bounced_dir = up_left;
            2'b10:   bounced_dir = down_right;
            default: bounced_dir = down_left;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn || motion.reset_objects) begin
            ball_x <= x_coord_t'(BALL_START_X);
            ball_y <= y_coord_t'(BALL_START_Y);
            dir    <= down_right;
        end else if (motion.bounce) begin
            dir <= bounced_dir;
        end else if (motion.move_ball) begin
            ball_x <= moving_left ? ball_x - 1'b1 : ball_x + 1'b1;
            ball_y <= moving_down ? ball_y + 1'b1 : ball_y - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn || motion.reset_objects) begin
            paddle_x <= x_coord_t'(PADDLE_START_X);
        end else if (motion.move_paddle) begin
            if (left_key) begin  // Left wins even when blocked
                if (paddle_x > 8'd1)
                    paddle_x <= paddle_x - 1'b1;
            end else if (right_key && paddle_x < PADDLE_MAX_X) begin
                paddle_x <= paddle_x + 1'b1;
            end
        end
    end

    // Flags hold until the next check
    always_ff @(posedge clk) begin
        if (!resetn) begin
            motion.touching_wall   <= 1'b0;
            motion.touching_paddle <= 1'b0;
            motion.hitting_floor   <= 1'b0;
        end else if (motion.check) begin
            motion.touching_wall   <= wall_hit;
            motion.touching_paddle <= paddle_hit;
            motion.hitting_floor   <= (ball_y >= FLOOR_Y);
        end
    end

endmodule

//--- hw/game_control.sv
module game_control #(
    parameter int unsigned FRAME_CYCLES = 16
) (
    input  logic     clk,
    input  logic     resetn,
    input  logic     go,
    input  logic     draw_done,
    motion_if.control motion,
    output logic     draw_start,
    output logic     score_inc,
    output logic     score_clear,
    output logic     playing
);
    import game_pkg::*;

    localparam int CNT_W = (FRAME_CYCLES > 1) ? $clog2(FRAME_CYCLES) : 1;

    game_state_e      state, next_state;
    logic [CNT_W-1:0] wait_cnt;
    logic             wait_done;
    logic             start_game;

    assign start_game = (state == idle) && go;
    assign wait_done  = (wait_cnt == CNT_W'(FRAME_CYCLES - 1));

    always_comb begin
        next_state = state;
        unique case (state)
            idle:        if (start_game) next_state = draw;
            draw:        if (draw_done) next_state = frame_wait;
            frame_wait:  if (wait_done) next_state = move_paddle;
            move_paddle: next_state = check;
            check:       next_state = resolve;
            resolve:     next_state = motion.hitting_floor ? game_over : move_ball;
            move_ball:   next_state = draw;
            game_over:   next_state = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state      <= idle;
            draw_start <= 1'b0;
            playing    <= 1'b0;
        end else begin
            state      <= next_state;
            draw_start <= (next_state == draw) && (state != draw);  // Once per frame
            if (start_game)
                playing <= 1'b1;
            else if (state == game_over)
                playing <= 1'b0;
        end
    end

    // Frame wait length, counted from entry into frame_wait
    always_ff @(posedge clk) begin
        if (!resetn || state != frame_wait)
            wait_cnt <= '0;
        else
            wait_cnt <= wait_cnt + 1'b1;
    end

    assign score_clear          = start_game;
    assign motion.reset_objects = start_game;
    assign motion.move_paddle   = (state == move_paddle);
    assign motion.check         = (state == check);
    assign motion.move_ball     = (state == move_ball);

    // Floor wins over paddle, paddle over wall
    assign score_inc     = (state == resolve) && !motion.hitting_floor && motion.touching_paddle;
    assign motion.bounce = (state == resolve) && !motion.hitting_floor
                           && (motion.touching_paddle || motion.touching_wall);

endmodule

//--- hw/motion_if.sv
interface motion_if;

    // One-cycle commands from the frame sequencer
    logic reset_objects;
    logic move_paddle;
    logic check;
    logic bounce;
    logic move_ball;

    // Collision flags, valid from the cycle after check
    logic touching_wall;
    logic touching_paddle;
    logic hitting_floor;

    modport control (
        output reset_objects, move_paddle, check, bounce, move_ball,
        input  touching_wall, touching_paddle, hitting_floor
    );

    modport playfield (
        input  reset_objects, move_paddle, check, bounce, move_ball,
        output touching_wall, touching_paddle, hitting_floor
    );

endinterface

//--- hw/pixel_pkg.sv
package pixel_pkg;

    // 160x120 frame buffer addressing
    typedef logic [7:0] x_coord_t;
    typedef logic [6:0] y_coord_t;

    // One bit per RGB channel
    typedef logic [2:0] colour_t;

    localparam colour_t BALL_COLOUR   = 3'd7;   // White
    localparam colour_t PADDLE_COLOUR = 3'd3;   // Cyan

endpackage

//--- hw/game_pkg.sv
package game_pkg;

    // Playfield in frame buffer pixels
    localparam int unsigned SCREEN_WIDTH  = 160;
    localparam int unsigned SCREEN_HEIGHT = 120;
    localparam int unsigned PADDLE_WIDTH  = 18;   // Paddle is 2 rows high

    // Start positions
    localparam int unsigned BALL_START_X   = 78;
    localparam int unsigned BALL_START_Y   = 58;
    localparam int unsigned PADDLE_START_X = 71;

    // Ball coordinates where it meets the walls, paddle and floor
    localparam int unsigned WALL_RIGHT_X  = SCREEN_WIDTH - 5;    // 155
    localparam int unsigned PADDLE_LINE_Y = SCREEN_HEIGHT - 7;   // 113
    localparam int unsigned FLOOR_Y       = SCREEN_HEIGHT - 5;   // 115

    // Paddle stays clear of the right wall
    localparam int unsigned PADDLE_MAX_X = SCREEN_WIDTH - PADDLE_WIDTH - 2;  // 140

    typedef enum logic [1:0] {
        up_right   = 2'd0,
        down_right = 2'd1,
        down_left  = 2'd2,
        up_left    = 2'd3
    } ball_dir_e;

    typedef enum logic [2:0] {
        idle,
        draw,
        frame_wait,
        move_paddle,
        check,
        resolve,
        move_ball,
        game_over
    } game_state_e;

endpackage
